// ==== btc_init.f ====
+incdir+hdl
hdl/btc_init_pkg.sv
hdl/btc_llr_splitter.sv
hdl/btc_row_init.sv
hdl/btc_result_collector.sv
hdl/btc_init_top.sv
sim/btc_init_checker.sv
sim/btc_init_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator; exit status follows the result

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module btc_init_tb \
  -f btc_init.f -o sim_btc_init > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_btc_init > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Errors found" sim.log; then
  echo "FAIL"
  exit 1
fi

if ! grep -q "No errors" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi

echo "PASS"
exit 0

// ==== sim/btc_init_tb.sv ====
// one row per lane per table entry; gaps between beats are random, each wait bounded by a timeout
`timescale 1ns/1ps
`include "btc_init_defines.svh"

module btc_init_tb;

  import btc_init_pkg::*;

  localparam int MAX_TESTS = 16;
  localparam int TIMEOUT   = 400;

  logic         iclk;
  logic         ireset;
  code_size_t   code_size;
  logic         val;
  strb_t        strb;
  llr_vec_t     llr;
  logic         res_val;
  row_result_t  res;
  logic [127:0] test_name;
  int           err_cnt;
  int           res_cnt;
  int           timeout_cnt;
  logic [31:0]  lcg_state;

  // stimulus table
  int           num_tests;
  logic [127:0] t_name [MAX_TESTS];
  code_size_t   t_size [MAX_TESTS];
  bit           t_rand [MAX_TESTS];
  int           t_flip [MAX_TESTS];

  // codeword bits, then soft values, per lane
  bit           row_c [`BTC_NUM_LANES][`BTC_ROW_MAX];
  llr_t         row_v [`BTC_NUM_LANES][`BTC_ROW_MAX];

  // ------------------------------
  // clock, DUT and checker
  // ------------------------------

  always #10 iclk = ~iclk;

  btc_init_top dut (
    .iclk      (iclk),
    .ireset    (ireset),
    .code_size (code_size),
    .val       (val),
    .strb      (strb),
    .llr       (llr),
    .res_val   (res_val),
    .res       (res)
  );

  btc_init_checker chk (
    .iclk      (iclk),
    .ireset    (ireset),
    .code_size (code_size),
    .val       (val),
    .strb      (strb),
    .llr       (llr),
    .test_name (test_name),
    .res_val   (res_val),
    .res       (res),
    .err_cnt   (err_cnt),
    .res_cnt   (res_cnt)
  );

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(input int range, output int v);
    lcg_state = lcg_next(lcg_state);
    v = int'(lcg_state[31:8] % range);
  endtask

  task automatic add_test(input logic [127:0] nm, input code_size_t cs, input bit rnd,
                          input int flips);
    t_name[num_tests] = nm;
    t_size[num_tests] = cs;
    t_rand[num_tests] = rnd;
    t_flip[num_tests] = flips;
    num_tests++;
  endtask

  // hamming codeword (random or all zero), then flipped hard bits, then soft values
  task automatic build_row(input int lane, input int t);
    int n;
    int m;
    int fpoly;
    int s;
    int v;
    int p1;
    int p2;
    bit par;
    m = 3 + int'(t_size[t]);
    n = 8 << int'(t_size[t]);
    case (t_size[t])
      BSIZE_16: fpoly = 32'h10 | int'(`BTC_POLY_16);
      BSIZE_32: fpoly = 32'h20 | int'(`BTC_POLY_32);
      BSIZE_64: fpoly = 32'h40 | int'(`BTC_POLY_64);
      default:  fpoly = 32'h08 | int'(`BTC_POLY_8);
    endcase
    for (int i = 0; i < n; i++) begin
      row_c[lane][i] = 1'b0;
      if (t_rand[t] && i < n - 1 - m) begin
        draw(2, v);
        row_c[lane][i] = v[0];
      end
    end
    // the last m data positions weigh alpha^(m-1)..alpha^0, they cancel the syndrome
    s = 0;
    for (int i = 0; i < n - 1; i++) begin
      s = (s << 1) ^ int'(row_c[lane][i]);
      if (((s >> m) & 1) == 1) begin
        s = s ^ fpoly;
      end
    end
    for (int j = 0; j < m; j++) begin
      row_c[lane][n - 2 - j] = s[j];
    end
    par = 1'b0;
    for (int i = 0; i < n - 1; i++) begin
      par = par ^ row_c[lane][i];
    end
    row_c[lane][n - 1] = par;
    draw(n, p1);
    p2 = (p1 + 1 + (p1 % (n - 1))) % n;
    if (t_flip[t] >= 1) begin
      row_c[lane][p1] = ~row_c[lane][p1];
    end
    if (t_flip[t] >= 2) begin
      row_c[lane][p2] = ~row_c[lane][p2];
    end
    // bit 0 maps to a non-negative llr
    for (int i = 0; i < n; i++) begin
      draw(16, v);
      row_v[lane][i] = row_c[lane][i] ? llr_t'(-(v + 1)) : llr_t'(v);
    end
  endtask

  task automatic apply_row(input int t);
    int n;
    int g;
    n = 8 << int'(t_size[t]);
    for (int i = 0; i < n; i++) begin
      draw(4, g);
      if (g == 0) begin
        @(posedge iclk);
        val <= 1'b0;
      end
      @(posedge iclk);
      val       <= 1'b1;
      strb      <= '{sop: (i == 0), eop: (i == n - 1)};
      code_size <= t_size[t];
      test_name <= t_name[t];
      for (int k = 0; k < `BTC_NUM_LANES; k++) begin
        llr[k] <= row_v[k][i];
      end
    end
    @(posedge iclk);
    val  <= 1'b0;
    strb <= '0;
  endtask

  task automatic wait_results(input int target, input logic [127:0] nm);
    int cnt;
    cnt = 0;
    while (res_cnt < target && cnt < TIMEOUT) begin
      @(posedge iclk);
      cnt++;
    end
    if (res_cnt < target) begin
      timeout_cnt++;
      $display("timeout, results of test %0s did not arrive", nm);
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int target;
    iclk        = 1'b0;
    ireset      = 1'b1;
    code_size   = BSIZE_8;
    val         = 1'b0;
    strb        = '0;
    llr         = '0;
    test_name   = '0;
    timeout_cnt = 0;
    num_tests   = 0;
    lcg_state   = 32'hfd4a_d059;

    add_test("zero_8_f0", BSIZE_8, 1'b0, 0);
    add_test("zero_64_f0", BSIZE_64, 1'b0, 0);
    add_test("rand_8_f0", BSIZE_8, 1'b1, 0);
    add_test("rand_16_f0", BSIZE_16, 1'b1, 0);
    add_test("rand_32_f0", BSIZE_32, 1'b1, 0);
    add_test("rand_64_f0", BSIZE_64, 1'b1, 0);
    add_test("zero_32_f1", BSIZE_32, 1'b0, 1);
    add_test("rand_8_f1", BSIZE_8, 1'b1, 1);
    add_test("rand_16_f1", BSIZE_16, 1'b1, 1);
    add_test("rand_32_f1", BSIZE_32, 1'b1, 1);
    add_test("rand_64_f1", BSIZE_64, 1'b1, 1);
    add_test("zero_8_f2", BSIZE_8, 1'b0, 2);
    add_test("rand_16_f2", BSIZE_16, 1'b1, 2);
    add_test("rand_64_f2", BSIZE_64, 1'b1, 2);

    repeat (16) @(posedge iclk);
    ireset <= 1'b0;
    @(posedge iclk);

    for (int t = 0; t < num_tests; t++) begin
      for (int k = 0; k < `BTC_NUM_LANES; k++) begin
        build_row(k, t);
      end
      target = res_cnt + `BTC_NUM_LANES;
      apply_row(t);
      wait_results(target, t_name[t]);
    end
    repeat (4) @(posedge iclk);

    $display("results %0d value errors %0d timeouts %0d", res_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sim/btc_init_checker.sv ====
// watches the top ports only; expects rows of 8..64 beats and results in lane order after each row
`timescale 1ns/1ps
`include "btc_init_defines.svh"

module btc_init_checker (
  input  logic                      iclk,
  input  logic                      ireset,
  input  btc_init_pkg::code_size_t  code_size,
  input  logic                      val,
  input  btc_init_pkg::strb_t       strb,
  input  btc_init_pkg::llr_vec_t    llr,
  input  logic [127:0]              test_name,
  input  logic                      res_val,
  input  btc_init_pkg::row_result_t res,
  output int                        err_cnt,
  output int                        res_cnt
);

  import btc_init_pkg::*;

  // soft values of the row being received, per lane
  llr_t         row_llr [`BTC_NUM_LANES][`BTC_ROW_MAX];
  int           bit_pos;
  longint       cyc;
  // expected results, oldest first
  lane_result_t exp_res_q[$];
  int           exp_lane_q[$];
  longint       exp_cyc_q[$];
  logic [127:0] exp_name_q[$];

  // ------------------------------
  // code parameters
  // ------------------------------

  // full primitive polynomial, top term included
  function automatic int full_poly(input code_size_t cs);
    case (cs)
      BSIZE_16: full_poly = 32'h10 | int'(`BTC_POLY_16);
      BSIZE_32: full_poly = 32'h20 | int'(`BTC_POLY_32);
      BSIZE_64: full_poly = 32'h40 | int'(`BTC_POLY_64);
      default:  full_poly = 32'h08 | int'(`BTC_POLY_8);
    endcase
  endfunction

  // alpha^e in the field of degree m
  function automatic int alpha_pow(input int e, input int m, input int fpoly);
    int a;
    a = 1;
    for (int i = 0; i < e; i++) begin
      a = a << 1;
      if (((a >> m) & 1) == 1) begin
        a = a ^ fpoly;
      end
    end
    alpha_pow = a;
  endfunction

  // ------------------------------
  // row model
  // ------------------------------

  function automatic lane_result_t model_row(input int lane, input int n, input code_size_t cs);
    lane_result_t r;
    int           mag [`BTC_ROW_MAX];
    bit           used [`BTC_ROW_MAX];
    int           v;
    int           best;
    int           m;
    int           fpoly;
    int           s;
    int           hd;
    bit           ev;
    bit           sp;
    r     = '0;
    m     = 3 + int'(cs);
    fpoly = full_poly(cs);
    ev    = 1'b0;
    sp    = 1'b0;
    s     = 0;
    for (int i = 0; i < n; i++) begin
      v       = int'(row_llr[lane][i]);
      mag[i]  = (v < 0) ? -v : v;
      used[i] = 1'b0;
      // hard decision 1 for a non-negative llr
      hd      = (v >= 0) ? 1 : 0;
      ev      = ev ^ hd[0];
      sp      = sp ^ (v < 0);
      // division over all but the parity bit, first bit first
      if (i < n - 1) begin
        s = (s << 1) ^ hd;
        if (((s >> m) & 1) == 1) begin
          s = s ^ fpoly;
        end
      end
    end
    // four smallest, earlier index first on a tie
    for (int k = 0; k < 4; k++) begin
      best = -1;
      for (int i = 0; i < n; i++) begin
        if (!used[i] && (best < 0 || mag[i] < mag[best])) begin
          best = i;
        end
      end
      used[best]   = 1'b1;
      r.lpp_idx[k] = bit_idx_t'(best);
      r.lpp_mag[k] = mag_t'(mag[best]);
    end
    r.spc_sign = sp;
    r.even     = ev;
    r.syndrome = 8'(s);
    // position i weighs alpha^(n-2-i); zero syndrome points at the parity bit
    r.err_idx  = bit_idx_t'(n - 1);
    if (s != 0) begin
      for (int p = 0; p < n - 1; p++) begin
        if (alpha_pow(n - 2 - p, m, fpoly) == s) begin
          r.err_idx = bit_idx_t'(p);
        end
      end
    end
    r.decfail  = (s != 0) && !ev;
    model_row  = r;
  endfunction

  task automatic check_val(input logic [127:0] tname, input string what,
                           input longint expv, input longint actv);
    if (expv != actv) begin
      err_cnt++;
      $display("error %0s %0s expected %0h actual %0h", tname, what, expv, actv);
    end
  endtask

  // ------------------------------
  // input capture and output compare
  // ------------------------------

  initial begin
    err_cnt = 0;
    res_cnt = 0;
    bit_pos = 0;
    cyc     = 0;
  end

  always @(posedge iclk) begin
    lane_result_t e;
    logic [127:0] nm;
    int           pos;
    cyc++;
    if (!ireset) begin
      if (res_val) begin
        res_cnt++;
        if (exp_res_q.size() == 0) begin
          err_cnt++;
          $display("result for lane %0d arrived with no row pending", res.lane);
        end else begin
          e  = exp_res_q.pop_front();
          nm = exp_name_q.pop_front();
          check_val(nm, "lane", exp_lane_q.pop_front(), res.lane);
          check_val(nm, "cycle", exp_cyc_q.pop_front(), cyc);
          for (int k = 0; k < 4; k++) begin
            check_val(nm, $sformatf("lpp_idx%0d", k), e.lpp_idx[k], res.result.lpp_idx[k]);
            check_val(nm, $sformatf("lpp_mag%0d", k), e.lpp_mag[k], res.result.lpp_mag[k]);
          end
          check_val(nm, "spc_sign", e.spc_sign, res.result.spc_sign);
          check_val(nm, "syndrome", e.syndrome, res.result.syndrome);
          check_val(nm, "even", e.even, res.result.even);
          check_val(nm, "err_idx", e.err_idx, res.result.err_idx);
          check_val(nm, "decfail", e.decfail, res.result.decfail);
        end
      end
      if (val) begin
        pos = strb.sop ? 0 : bit_pos;
        for (int k = 0; k < `BTC_NUM_LANES; k++) begin
          row_llr[k][pos] = llr[k];
        end
        bit_pos = pos + 1;
        if (strb.eop) begin
          for (int k = 0; k < `BTC_NUM_LANES; k++) begin
            exp_res_q.push_back(model_row(k, pos + 1, code_size));
            exp_lane_q.push_back(k);
            exp_cyc_q.push_back(cyc + 4 + k);
            exp_name_q.push_back(test_name);
          end
        end
      end
    end
  end

endmodule

// ==== hdl/btc_init_top.sv ====
// no back-pressure and no clock enable; lane k result leaves 4+k cycles after the eop beat
`timescale 1ns/1ps
`include "btc_init_defines.svh"

module btc_init_top (
  input  logic                     iclk,
  input  logic                     ireset,
  input  btc_init_pkg::code_size_t code_size,
  input  logic                     val,
  input  btc_init_pkg::strb_t      strb,
  input  btc_init_pkg::llr_vec_t   llr,
  output logic                     res_val,
  output btc_init_pkg::row_result_t res
);

  import btc_init_pkg::*;

  llr_beat_t                         beat;
  ham_cfg_t                          cfg;
  // all lanes finish together, lane 0 stands for them
  logic                              row_done;
  lane_result_t [`BTC_NUM_LANES-1:0] lane_res;

  // ------------------------------
  // input register and decode
  // ------------------------------

  btc_llr_splitter u_splitter (
    .iclk      (iclk),
    .ireset    (ireset),
    .code_size (code_size),
    .val       (val),
    .strb      (strb),
    .llr       (llr),
    .beat      (beat),
    .cfg       (cfg)
  );

  // ------------------------------
  // one lane per row
  // ------------------------------

  for (genvar k = 0; k < `BTC_NUM_LANES; k++) begin : g_lane
    if (k == 0) begin : g_first
      btc_row_init #(
        .LANE (k)
      ) u_lane (
        .iclk   (iclk),
        .ireset (ireset),
        .beat   (beat),
        .cfg    (cfg),
        .done   (row_done),
        .result (lane_res[k])
      );
    end else begin : g_other
      // same timing as lane 0, done left open
      btc_row_init #(
        .LANE (k)
      ) u_lane (
        .iclk   (iclk),
        .ireset (ireset),
        .beat   (beat),
        .cfg    (cfg),
        .done   (),
        .result (lane_res[k])
      );
    end
  end

  // ------------------------------
  // output serializer
  // ------------------------------

  btc_result_collector u_collector (
    .iclk     (iclk),
    .ireset   (ireset),
    .done     (row_done),
    .lane_res (lane_res),
    .res_val  (res_val),
    .res      (res)
  );

endmodule

// ==== hdl/btc_result_collector.sv ====
// rows must span at least BTC_NUM_LANES beats, otherwise a new done cuts the current burst short
`timescale 1ns/1ps
`include "btc_init_defines.svh"

module btc_result_collector (
  input  logic                                            iclk,
  input  logic                                            ireset,
  input  logic                                            done,
  input  btc_init_pkg::lane_result_t [`BTC_NUM_LANES-1:0] lane_res,
  output logic                                            res_val,
  output btc_init_pkg::row_result_t                       res
);

  import btc_init_pkg::*;

  col_state_t                        state;
  // lane sent on the next cycle
  lane_t                             cnt;
  lane_result_t [`BTC_NUM_LANES-1:0] res_buf;

  // ------------------------------
  // serializer control
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state   <= COL_IDLE;
      cnt     <= '0;
      res_val <= 1'b0;
    end else begin
      if (done) begin
        // lane 0 leaves right away, the rest follow from the buffer
        state   <= COL_SEND;
        cnt     <= lane_t'(1);
        res_val <= 1'b1;
      end else if (state == COL_SEND) begin
        cnt     <= cnt + 1'b1;
        res_val <= 1'b1;
        if (cnt == lane_t'(`BTC_NUM_LANES - 1)) begin
          state <= COL_IDLE;
        end
      end else begin
        res_val <= 1'b0;
      end
    end
  end

  // ------------------------------
  // result buffer and output
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (done) begin
      res_buf    <= lane_res;
      res.result <= lane_res[0];
      res.lane   <= '0;
    end else if (state == COL_SEND) begin
      res.result <= res_buf[cnt];
      res.lane   <= cnt;
    end
  end

endmodule

// ==== hdl/btc_row_init.sv ====
// LANE must be below BTC_NUM_LANES; err_idx is only meaningful for a single error, parity bit on zero syndrome
`timescale 1ns/1ps
`include "btc_init_defines.svh"

module btc_row_init #(
  parameter int LANE = 0
) (
  input  logic                       iclk,
  input  logic                       ireset,
  input  btc_init_pkg::llr_beat_t    beat,
  input  btc_init_pkg::ham_cfg_t     cfg,
  output logic                       done,
  output btc_init_pkg::lane_result_t result
);

  import btc_init_pkg::*;

  // this lane's soft value and hard decision
  llr_t           lane_llr;
  logic           hd;

  // stage 1
  logic           s1_val;
  logic           s1_sop;
  logic           s1_eop;
  bit_idx_t       s1_idx;
  mag_t           s1_mag;
  logic           s1_sign;

  // stage 2, running sort and sign product
  bit_idx_t [3:0] lpp_idx_q;
  bit_idx_t [3:0] lpp_idx_nxt;
  mag_t     [3:0] lpp_mag_q;
  mag_t     [3:0] lpp_mag_nxt;
  logic     [3:0] ins_hit;
  logic           spc_q;
  logic           spc_nxt;

  // hamming divider
  logic     [7:0] state_q;
  logic           even_q;
  logic           even_nxt;
  // snapshot taken on the eop beat
  logic     [7:0] ham_syn;
  logic           ham_even;
  logic     [7:0] ham_poly;
  logic     [2:0] ham_msb;
  bit_idx_t       ham_last;
  // locator walk
  logic     [7:0] pw_top;
  logic     [7:0] pw;
  bit_idx_t       loc_idx;

  assign lane_llr = beat.llr[LANE];
  // hard decision 1 for llr >= 0
  assign hd       = ~lane_llr[`BTC_LLR_W-1];

  // ------------------------------
  // stage 1 abs / sign split
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_val <= 1'b0;
      done   <= 1'b0;
    end else begin
      s1_val <= beat.val;
      // result registers load on the same edge
      done   <= s1_val & s1_eop;
    end
  end

  always_ff @(posedge iclk) begin
    if (beat.val) begin
      s1_sop  <= beat.strb.sop;
      s1_eop  <= beat.strb.eop;
      s1_idx  <= beat.idx;
      s1_sign <= lane_llr[`BTC_LLR_W-1];
      s1_mag  <= lane_llr[`BTC_LLR_W-1] ? mag_t'(-lane_llr) : mag_t'(lane_llr);
    end
  end

  // ------------------------------
  // stage 2 insertion sort
  // ------------------------------

  always_comb begin
    lpp_idx_nxt = lpp_idx_q;
    lpp_mag_nxt = lpp_mag_q;
    // strict compare, so an equal later magnitude never displaces an earlier one
    for (int i = 0; i < 4; i++) begin
      ins_hit[i] = (s1_mag < lpp_mag_q[i]);
    end
    if (s1_sop) begin
      // empty slots look as unreliable as possible
      lpp_idx_nxt    = '0;
      lpp_mag_nxt    = '1;
      lpp_idx_nxt[0] = s1_idx;
      lpp_mag_nxt[0] = s1_mag;
    end else begin
      if (ins_hit[0]) begin
        lpp_idx_nxt[0] = s1_idx;
        lpp_mag_nxt[0] = s1_mag;
      end
      // slots are ordered, so hits form a tail: shift below the first hit
      for (int i = 1; i < 4; i++) begin
        if (ins_hit[i]) begin
          lpp_idx_nxt[i] = ins_hit[i-1] ? lpp_idx_q[i-1] : s1_idx;
          lpp_mag_nxt[i] = ins_hit[i-1] ? lpp_mag_q[i-1] : s1_mag;
        end
      end
    end
    spc_nxt = s1_sop ? s1_sign : (spc_q ^ s1_sign);
  end

  always_ff @(posedge iclk) begin
    if (s1_val) begin
      lpp_idx_q <= lpp_idx_nxt;
      lpp_mag_q <= lpp_mag_nxt;
      spc_q     <= spc_nxt;
    end
    // final step goes straight to the result, held until the next row ends
    if (s1_val && s1_eop) begin
      result.lpp_idx  <= lpp_idx_nxt;
      result.lpp_mag  <= lpp_mag_nxt;
      result.spc_sign <= spc_nxt;
      result.syndrome <= ham_syn;
      result.even     <= ham_even;
      result.err_idx  <= loc_idx;
      result.decfail  <= (ham_syn != '0) & ~ham_even;
    end
  end

  // ------------------------------
  // hamming syndrome
  // ------------------------------

  // even covers every bit, parity bit included
  assign even_nxt = beat.strb.sop ? hd : (even_q ^ hd);

  // horner division, bit 0 enters first; bits above msb_sel are masked off later
  always_ff @(posedge iclk) begin
    if (beat.val) begin
      even_q <= even_nxt;
      if (beat.strb.sop) begin
        state_q <= {7'd0, hd};
      end else if (!beat.strb.eop) begin
        state_q <= (state_q << 1) ^ ({8{state_q[cfg.msb_sel]}} & cfg.poly) ^ {7'd0, hd};
      end
      // state is final before the parity bit; freeze it and the setup for the locator
      if (beat.strb.eop) begin
        ham_syn  <= state_q & cfg.mask;
        ham_even <= even_nxt;
        ham_poly <= cfg.poly;
        ham_msb  <= cfg.msb_sel;
        ham_last <= beat.idx;
      end
    end
  end

  // ------------------------------
  // error locator
  // ------------------------------

  // position i contributes alpha^(n-2-i); walk from alpha^(n-2) = alpha^-1 downwards
  assign pw_top = 8'd1 << ham_msb;

  always_comb begin
    pw      = (ham_poly >> 1) | pw_top;
    // zero syndrome with odd parity points at the parity bit
    loc_idx = ham_last;
    for (int i = 0; i < `BTC_ROW_MAX - 1; i++) begin
      if ((i < int'(ham_last)) && (pw == ham_syn) && (ham_syn != '0)) begin
        loc_idx = bit_idx_t'(i);
      end
      // multiply by alpha^-1: clear the constant term with the full poly, then divide by x
      pw = pw[0] ? (((pw ^ ham_poly) >> 1) | pw_top) : (pw >> 1);
    end
  end

endmodule

// ==== hdl/btc_llr_splitter.sv ====
// code_size must stay stable over a row; bit index counts valid beats only and restarts on sop
`timescale 1ns/1ps
`include "btc_init_defines.svh"

module btc_llr_splitter (
  input  logic                    iclk,
  input  logic                    ireset,
  input  btc_init_pkg::code_size_t code_size,
  input  logic                    val,
  input  btc_init_pkg::strb_t     strb,
  input  btc_init_pkg::llr_vec_t  llr,
  output btc_init_pkg::llr_beat_t beat,
  output btc_init_pkg::ham_cfg_t  cfg
);

  import btc_init_pkg::*;

  logic     val_q;
  strb_t    strb_q;
  bit_idx_t idx_q;
  llr_vec_t llr_q;
  // position of the next valid beat
  bit_idx_t idx_cnt;
  bit_idx_t cur_idx;
  ham_cfg_t cfg_dec;
  ham_cfg_t cfg_q;

  // ------------------------------
  // bit position counter
  // ------------------------------

  // sop always restarts the row at position 0
  assign cur_idx = strb.sop ? '0 : idx_cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val_q   <= 1'b0;
      idx_cnt <= '0;
    end else begin
      val_q <= val;
      if (val) begin
        idx_cnt <= cur_idx + 1'b1;
      end
    end
  end

  // ------------------------------
  // code size decode
  // ------------------------------

  always_comb begin
    cfg_dec = '{poly: `BTC_POLY_8, mask: 8'h07, msb_sel: 3'd2};
    case (code_size)
      BSIZE_16 : cfg_dec = '{poly: `BTC_POLY_16, mask: 8'h0f, msb_sel: 3'd3};
      BSIZE_32 : cfg_dec = '{poly: `BTC_POLY_32, mask: 8'h1f, msb_sel: 3'd4};
      BSIZE_64 : cfg_dec = '{poly: `BTC_POLY_64, mask: 8'h3f, msb_sel: 3'd5};
      default  : cfg_dec = '{poly: `BTC_POLY_8, mask: 8'h07, msb_sel: 3'd2};
    endcase
  end

  // payload moves only with a valid beat
  always_ff @(posedge iclk) begin
    if (val) begin
      strb_q <= strb;
      idx_q  <= cur_idx;
      llr_q  <= llr;
      cfg_q  <= cfg_dec;
    end
  end

  // one registered beat, shared by all lanes
  always_comb begin
    beat.val  = val_q;
    beat.strb = strb_q;
    beat.idx  = idx_q;
    beat.llr  = llr_q;
  end

  assign cfg = cfg_q;

endmodule

// ==== hdl/btc_init_pkg.sv ====
// shared types only; widths follow btc_init_defines.svh, lane field sized by BTC_LANE_W
`include "btc_init_defines.svh"

package btc_init_pkg;

  // ------------------------------
  // code and data types
  // ------------------------------

  // row length of the extended hamming / spc code
  typedef enum logic [1:0] {
    BSIZE_8  = 2'd0,
    BSIZE_16 = 2'd1,
    BSIZE_32 = 2'd2,
    BSIZE_64 = 2'd3
  } code_size_t;

  typedef logic signed [`BTC_LLR_W-1:0] llr_t;
  // abs value, unsigned so that -2^(W-1) still fits
  typedef logic [`BTC_LLR_W-1:0] mag_t;
  typedef logic [`BTC_IDX_W-1:0] bit_idx_t;
  typedef logic [`BTC_LANE_W-1:0] lane_t;

  // one LLR per lane
  typedef llr_t [`BTC_NUM_LANES-1:0] llr_vec_t;

  // start and end of row markers
  typedef struct packed {
    logic sop;
    logic eop;
  } strb_t;

  // registered beat handed to every lane
  typedef struct packed {
    logic     val;
    strb_t    strb;
    bit_idx_t idx;
    llr_vec_t llr;
  } llr_beat_t;

  // hamming divider setup, decoded once per beat
  // msb_sel points at the feedback bit, i.e. degree - 1
  typedef struct packed {
    logic [7:0] poly;
    logic [7:0] mask;
    logic [2:0] msb_sel;
  } ham_cfg_t;

  // ------------------------------
  // lane and output results
  // ------------------------------

  // entry 0 is the least reliable position
  typedef struct packed {
    bit_idx_t [3:0] lpp_idx;
    mag_t     [3:0] lpp_mag;
    logic           spc_sign;
    logic     [7:0] syndrome;
    logic           even;
    bit_idx_t       err_idx;
    logic           decfail;
  } lane_result_t;

  typedef struct packed {
    lane_result_t result;
    lane_t        lane;
  } row_result_t;

  // output serializer states
  typedef enum logic {
    COL_IDLE = 1'b0,
    COL_SEND = 1'b1
  } col_state_t;

endpackage

// ==== hdl/btc_init_defines.svh ====
// sizes fixed at build time; rows of 8..64 bits, 5-bit LLRs, no runtime check of these limits
`ifndef BTC_INIT_DEFINES_SVH
`define BTC_INIT_DEFINES_SVH

// ------------------------------
// data path widths
// ------------------------------

// soft input, signed two's complement
`define BTC_LLR_W      5
// rows received side by side, one LLR each per beat
`define BTC_NUM_LANES  4
// lane number carried with every result, must cover BTC_NUM_LANES
`define BTC_LANE_W     2
// bit position inside a row
`define BTC_IDX_W      6
// longest extended hamming row
`define BTC_ROW_MAX    64

// ------------------------------
// primitive polynomials
// ------------------------------

// top term dropped, zero extended to 8 bits
// x^3 + x + 1
`define BTC_POLY_8     8'h03
// x^4 + x + 1
`define BTC_POLY_16    8'h03
// x^5 + x^2 + 1
`define BTC_POLY_32    8'h05
// x^6 + x + 1
`define BTC_POLY_64    8'h03

`endif
